//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= floor_controller_tb
RTL_TOP   ?= floor_controller
FILELIST  ?= floor_controller.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) elevator_pkg.sv call_scanner.sv \
		request_arbiter.sv request_queue.sv car_dispatcher.sv floor_controller.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- call_scanner.sv
//////////////////////////////
// Holds one pending request at a time; presses during the wait are dropped
//////////////////////////////
`timescale 1ns/1ps

module call_scanner #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [NUM_FLOORS-1:0]        buttons,
    input  elevator_pkg::floor_t         current_floor,
    input  logic                         power_on,
    input  logic                         emergency_button,
    input  logic                         grant,
    input  logic                         arrival,
    input  elevator_pkg::floor_t         arrival_floor,
    output elevator_pkg::floor_request_t request,
    output logic [NUM_FLOORS-1:0]        lamps
);
    import elevator_pkg::*;

    logic   press_found;
    floor_t press_floor;

    // Lowest pressed button that is dark and not the car's floor
    always_comb begin
        press_found = 1'b0;
        press_floor = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (buttons[i] && !lamps[i] && current_floor != FLOOR_W'(i)) begin
                press_found = 1'b1;
                press_floor = FLOOR_W'(i);
            end
        end
    end

    // Pending request, released by the grant
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            request <= '0;
        end else if (request.valid) begin
            if (grant) begin
                request.valid <= 1'b0;
            end
        end else if (power_on && !emergency_button && press_found) begin
            request.valid <= 1'b1;
            request.floor <= press_floor;
        end
    end

    // Lamp lights when the queue takes the request
    // A grant on the arrival floor keeps its lamp lit since the new entry is still queued
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lamps <= '0;
        end else begin
            if (arrival) begin
                lamps[arrival_floor] <= 1'b0;
            end
            if (grant && request.valid) begin
                lamps[request.floor] <= 1'b1;
            end
        end
    end

endmodule

//--- car_dispatcher.sv
//////////////////////////////
// Serves one target at a time; car motion is modelled outside
//////////////////////////////
`timescale 1ns/1ps

module car_dispatcher (
    input  logic                 clock,
    input  logic                 reset_n,
    input  elevator_pkg::floor_t head,
    input  logic                 empty,
    input  elevator_pkg::floor_t current_floor,
    input  logic                 car_moving,
    input  logic                 power_on,
    input  logic                 emergency_button,
    input  logic                 door_open_button,
    input  logic                 door_close_button,
    output logic                 pop,
    output elevator_pkg::floor_t target_floor,
    output logic                 direction_up,
    output logic                 activate,
    output logic                 arrival,
    output elevator_pkg::floor_t arrival_floor,
    output logic                 door_open_allowed,
    output logic                 door_close_allowed
);
    import elevator_pkg::*;

    dispatch_state_t state;
    logic            enabled;
    logic            at_target;

    assign enabled   = power_on && !emergency_button;
    assign at_target = !car_moving && current_floor == target_floor;

    //////////////////////////////
    // Car commands
    //////////////////////////////

    assign pop           = state == dispatch_idle && !empty && !car_moving && enabled;
    assign activate      = state == dispatch_travel && enabled && current_floor != target_floor;
    assign direction_up  = target_floor > current_floor;
    assign arrival       = state == dispatch_arrive;
    assign arrival_floor = target_floor;

    // Next target is taken from the queue head as it is popped
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= dispatch_idle;
            target_floor <= '0;
        end else begin
            case (state)
                dispatch_idle: begin
                    if (pop) begin
                        state        <= dispatch_travel;
                        target_floor <= head;
                    end
                end
                dispatch_travel: begin
                    if (at_target) begin
                        state <= dispatch_arrive;
                    end
                end
                dispatch_arrive: state <= dispatch_idle;
                default:         state <= dispatch_idle;
            endcase
        end
    end

    //////////////////////////////
    // Door permissions
    //////////////////////////////

    // Stopped and powered only
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_button && !car_moving && power_on;
            door_close_allowed <= door_close_button && !car_moving && power_on;
        end
    end

endmodule

//--- elevator_pkg.sv
//////////////////////////////
// Floor 0 is the lowest landing; FLOOR_W limits a car to 16 floors
//////////////////////////////
package elevator_pkg;

    //////////////////////////////
    // Floor encoding
    //////////////////////////////

    // Bits in a floor index
    parameter int FLOOR_W = 4;

    typedef logic [FLOOR_W-1:0] floor_t;

    // Offered by a scanner, and the queue write once granted
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_request_t;

    //////////////////////////////
    // Dispatcher states
    //////////////////////////////

    // Idle has no target
    // Travel holds a target and may ask the car to move
    // Arrive lasts one cycle and strobes arrival
    typedef enum logic [1:0] {
        dispatch_idle   = 2'd0,
        dispatch_travel = 2'd1,
        dispatch_arrive = 2'd2
    } dispatch_state_t;

endpackage

//--- floor_controller.f
elevator_pkg.sv
call_scanner.sv
request_arbiter.sv
request_queue.sv
car_dispatcher.sv
floor_controller.sv
tb_clock_gen.sv
floor_controller_props.sv
floor_controller_tb.sv

//--- floor_controller.sv
//////////////////////////////
// Two scanners share one request queue; the car itself is driven from outside
//////////////////////////////
`timescale 1ns/1ps

module floor_controller #(
    parameter int NUM_FLOORS  = 11,
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [NUM_FLOORS-1:0] car_buttons,
    input  logic [NUM_FLOORS-1:0] hall_buttons,
    input  logic                  door_open_button,
    input  logic                  door_close_button,
    input  logic                  emergency_button,
    input  logic                  power_on,
    input  elevator_pkg::floor_t  current_floor,
    input  logic                  car_moving,
    output elevator_pkg::floor_t  target_floor,
    output logic                  direction_up,
    output logic                  activate,
    output logic [NUM_FLOORS-1:0] car_lamps,
    output logic [NUM_FLOORS-1:0] hall_lamps,
    output logic                  door_open_allowed,
    output logic                  door_close_allowed
);
    import elevator_pkg::*;

    floor_request_t car_request;
    floor_request_t hall_request;
    floor_request_t queue_write;
    logic           car_grant;
    logic           hall_grant;
    logic           full;
    logic           empty;
    logic           pop;
    floor_t         head;
    logic           arrival;
    floor_t         arrival_floor;

    //////////////////////////////
    // Request capture
    //////////////////////////////

    call_scanner #(
        .NUM_FLOORS(NUM_FLOORS)
    ) car_scanner (
        .clock            (clock),
        .reset_n          (reset_n),
        .buttons          (car_buttons),
        .current_floor    (current_floor),
        .power_on         (power_on),
        .emergency_button (emergency_button),
        .grant            (car_grant),
        .arrival          (arrival),
        .arrival_floor    (arrival_floor),
        .request          (car_request),
        .lamps            (car_lamps)
    );

    call_scanner #(
        .NUM_FLOORS(NUM_FLOORS)
    ) hall_scanner (
        .clock            (clock),
        .reset_n          (reset_n),
        .buttons          (hall_buttons),
        .current_floor    (current_floor),
        .power_on         (power_on),
        .emergency_button (emergency_button),
        .grant            (hall_grant),
        .arrival          (arrival),
        .arrival_floor    (arrival_floor),
        .request          (hall_request),
        .lamps            (hall_lamps)
    );

    request_arbiter u_arbiter (
        .car_request  (car_request),
        .hall_request (hall_request),
        .full         (full),
        .car_grant    (car_grant),
        .hall_grant   (hall_grant),
        .queue_write  (queue_write)
    );

    //////////////////////////////
    // Queue and dispatch
    //////////////////////////////

    request_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clock   (clock),
        .reset_n (reset_n),
        .write   (queue_write),
        .pop     (pop),
        .head    (head),
        .full    (full),
        .empty   (empty)
    );

    car_dispatcher u_dispatcher (
        .clock              (clock),
        .reset_n            (reset_n),
        .head               (head),
        .empty              (empty),
        .current_floor      (current_floor),
        .car_moving         (car_moving),
        .power_on           (power_on),
        .emergency_button   (emergency_button),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .pop                (pop),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate           (activate),
        .arrival            (arrival),
        .arrival_floor      (arrival_floor),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

//--- floor_controller_props.sv
//////////////////////////////
// Bound twice; unused inputs of each binding are tied inactive
//////////////////////////////
`timescale 1ns/1ps

module floor_controller_props (
    input logic                          clock,
    input logic                          reset_n,
    input elevator_pkg::dispatch_state_t state,
    input logic                          activate,
    input logic                          arrival,
    input logic                          pop,
    input logic                          empty,
    input logic                          write_valid,
    input logic                          full
);
    import elevator_pkg::*;

    idle_no_activate: assert property (@(posedge clock) disable iff (!reset_n)
        state == dispatch_idle |-> !activate)
        else $error("activate high while the dispatcher is idle");

    arrival_one_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        arrival |=> !arrival)
        else $error("arrival strobe longer than one cycle");

    no_pop_when_empty: assert property (@(posedge clock) disable iff (!reset_n)
        !(pop && empty))
        else $error("pop while the queue is empty");

    no_write_when_full: assert property (@(posedge clock) disable iff (!reset_n)
        !(write_valid && full))
        else $error("queue write while the queue is full");

endmodule

//--- floor_controller_tb.sv
//////////////////////////////
// Cycle model of the controller checked at every falling edge
//////////////////////////////
`timescale 1ns/1ps

module floor_controller_tb;
    import elevator_pkg::*;

    localparam int NF             = 11;
    localparam int QD             = 16;
    localparam int REQUEST_COUNT  = 100;
    localparam int TIMEOUT_CYCLES = 40 * REQUEST_COUNT + 200;

    logic clock;
    logic reset_n;
    logic [NF-1:0] car_buttons, hall_buttons, car_lamps, hall_lamps;
    logic door_open_button, door_close_button, emergency_button, power_on, car_moving;
    logic direction_up, activate, door_open_allowed, door_close_allowed;
    floor_t current_floor, target_floor;

    // Model state
    logic m_car_valid, m_hall_valid, m_door_open, m_door_close;
    floor_t m_car_floor, m_hall_floor, m_target;
    logic [NF-1:0] m_car_lamps, m_hall_lamps;
    floor_t m_queue[$];
    dispatch_state_t m_state;

    // Car model state
    logic hold_moving, act_seen;
    floor_t tgt_seen;
    int step_count, cycle_count;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_controller #(.NUM_FLOORS(NF), .QUEUE_DEPTH(QD)) dut (.*);

    bind car_dispatcher floor_controller_props dispatcher_props (
        .clock(clock), .reset_n(reset_n), .state(state), .activate(activate),
        .arrival(arrival), .pop(pop), .empty(empty), .write_valid(1'b0), .full(1'b0)
    );
    bind request_queue floor_controller_props queue_props (
        .clock(clock), .reset_n(reset_n), .state(elevator_pkg::dispatch_idle),
        .activate(1'b0), .arrival(1'b0), .pop(pop), .empty(empty),
        .write_valid(write.valid), .full(full)
    );

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        stop_with_failure($sformatf("MISMATCH %s dut=%h expected=%h", name, got, want));
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Lowest pressed button that is dark and not the car's floor, or -1
    function automatic int lowest_press(input logic [NF-1:0] buttons,
                                        input logic [NF-1:0] lamps, input floor_t cur);
        int found;
        found = -1;
        for (int i = 0; i < NF; i++) begin
            if (found < 0 && buttons[i] && !lamps[i] && int'(cur) != i) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic reset_model();
        m_car_valid = 0;
        m_hall_valid = 0;
        m_car_floor = '0;
        m_hall_floor = '0;
        m_car_lamps = '0;
        m_hall_lamps = '0;
        m_queue.delete();
        m_state = dispatch_idle;
        m_target = '0;
        m_door_open = 0;
        m_door_close = 0;
    endtask

    task automatic advance_model();
        logic enabled, full, empty, hall_grant, car_grant, pop_now;
        floor_t head_now;
        int car_pick, hall_pick;
        enabled    = power_on && !emergency_button;
        full       = m_queue.size() == QD;
        empty      = m_queue.size() == 0;
        hall_grant = m_hall_valid && !full;
        car_grant  = m_car_valid && !m_hall_valid && !full;
        pop_now    = m_state == dispatch_idle && !empty && !car_moving && enabled;
        head_now   = empty ? '0 : m_queue[0];
        car_pick   = lowest_press(car_buttons, m_car_lamps, current_floor);
        hall_pick  = lowest_press(hall_buttons, m_hall_lamps, current_floor);
        if (m_state == dispatch_arrive) begin
            m_car_lamps[int'(m_target)]  = 1'b0;
            m_hall_lamps[int'(m_target)] = 1'b0;
        end
        if (car_grant) m_car_lamps[int'(m_car_floor)] = 1'b1;
        if (hall_grant) m_hall_lamps[int'(m_hall_floor)] = 1'b1;
        if (pop_now) void'(m_queue.pop_front());
        if (hall_grant) m_queue.push_back(m_hall_floor);
        else if (car_grant) m_queue.push_back(m_car_floor);
        // Scanners reload only when free
        if (m_car_valid) begin
            if (car_grant) m_car_valid = 0;
        end else if (enabled && car_pick >= 0) begin
            m_car_valid = 1;
            m_car_floor = floor_t'(car_pick);
        end
        if (m_hall_valid) begin
            if (hall_grant) m_hall_valid = 0;
        end else if (enabled && hall_pick >= 0) begin
            m_hall_valid = 1;
            m_hall_floor = floor_t'(hall_pick);
        end
        case (m_state)
            dispatch_idle: if (pop_now) begin
                m_state  = dispatch_travel;
                m_target = head_now;
            end
            dispatch_travel: begin
                if (!car_moving && current_floor == m_target) m_state = dispatch_arrive;
            end
            default: m_state = dispatch_idle;
        endcase
        m_door_open  = door_open_button && !car_moving && power_on;
        m_door_close = door_close_button && !car_moving && power_on;
    endtask

    initial reset_model();

    always @(posedge clock) begin
        if (!reset_n) reset_model();
        else advance_model();
    end

    // Comparison at the falling edge, where all outputs are settled
    always @(negedge clock) begin
        if (reset_n) begin
            assert (target_floor == m_target)
                else show_mismatch("target_floor", 32'(target_floor), 32'(m_target));
            assert (car_lamps == m_car_lamps)
                else show_mismatch("car_lamps", 32'(car_lamps), 32'(m_car_lamps));
            assert (hall_lamps == m_hall_lamps)
                else show_mismatch("hall_lamps", 32'(hall_lamps), 32'(m_hall_lamps));
            assert (activate == (m_state == dispatch_travel && power_on && !emergency_button
                                 && current_floor != m_target))
                else show_mismatch("activate", 32'(activate), 32'(!activate));
            assert (direction_up == (m_target > current_floor))
                else show_mismatch("direction_up", 32'(direction_up), 32'(!direction_up));
            assert (door_open_allowed == m_door_open)
                else show_mismatch("door_open_allowed", 32'(door_open_allowed), 32'(m_door_open));
            assert (door_close_allowed == m_door_close)
                else show_mismatch("door_close_allowed", 32'(door_close_allowed),
                                   32'(m_door_close));
        end
        act_seen = activate;
        tgt_seen = target_floor;
    end

    //////////////////////////////
    // Car model and timeout
    //////////////////////////////

    always @(posedge clock) begin
        #1;
        if (hold_moving) begin
            car_moving = 1'b1;
        end else if (act_seen) begin
            car_moving = 1'b1;
            step_count++;
            if (step_count == 4) begin
                step_count = 0;
                current_floor = tgt_seen > current_floor ? current_floor + 1'b1
                                                         : current_floor - 1'b1;
                if (current_floor == tgt_seen) car_moving = 1'b0;
            end
        end else begin
            car_moving = 1'b0;
            step_count = 0;
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with_failure("Timeout: the requests were not served in time");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic next_drive_slot();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_negedges(input int n);
        repeat (n) @(negedge clock);
    endtask

    // Buttons high for exactly one sampling edge
    task automatic press_buttons(input logic [NF-1:0] car_mask, input logic [NF-1:0] hall_mask);
        next_drive_slot();
        car_buttons  = car_mask;
        hall_buttons = hall_mask;
        next_drive_slot();
        car_buttons  = '0;
        hall_buttons = '0;
    endtask

    task automatic wait_until_served();
        @(negedge clock);
        while (m_queue.size() != 0 || m_state != dispatch_idle || m_car_valid
               || m_hall_valid || car_moving) begin
            @(negedge clock);
        end
    endtask

    // Queue a few floors, then hold the car off with the given condition
    task automatic check_blocked(input logic use_emergency);
        logic [NF-1:0] car_snap, hall_snap;
        hold_moving = 1;
        press_buttons(NF'(1) << 8, NF'(1) << 1);
        wait_negedges(4);
        next_drive_slot();
        if (use_emergency) emergency_button = 1;
        else power_on = 0;
        hold_moving = 0;
        wait_negedges(1);
        car_snap  = car_lamps;
        hall_snap = hall_lamps;
        press_buttons(NF'(1) << 9, NF'(1) << 3);
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            assert (!activate) else show_mismatch("activate", 32'(activate), 32'h0);
        end
        assert (car_lamps == car_snap)
            else show_mismatch("car_lamps", 32'(car_lamps), 32'(car_snap));
        assert (hall_lamps == hall_snap)
            else show_mismatch("hall_lamps", 32'(hall_lamps), 32'(hall_snap));
        next_drive_slot();
        emergency_button = 0;
        power_on = 1;
        wait_until_served();
    endtask

    initial begin
        int kind;
        logic [NF-1:0] lamp_snap;
        void'($urandom(32'h028a_2094));
        car_buttons = '0;
        hall_buttons = '0;
        door_open_button = 0;
        door_close_button = 0;
        emergency_button = 0;
        power_on = 1;
        current_floor = '0;
        car_moving = 0;
        hold_moving = 0;
        act_seen = 0;
        tgt_seen = '0;
        step_count = 0;
        cycle_count = 0;
        @(posedge reset_n);

        // Single request and arrival
        press_buttons(NF'(1) << 5, '0);
        wait_negedges(2);
        assert (car_lamps == NF'(1) << 5) else show_mismatch("car_lamps", 32'(car_lamps), 32'h20);
        while (!activate) @(negedge clock);
        assert (direction_up) else show_mismatch("direction_up", 32'(direction_up), 32'h1);
        // Hall call on the same floor, cleared by the same arrival
        press_buttons('0, NF'(1) << 5);
        wait_until_served();
        assert (!car_lamps[5]) else show_mismatch("car_lamps[5]", 32'h1, 32'h0);
        assert (!hall_lamps[5]) else show_mismatch("hall_lamps[5]", 32'h1, 32'h0);

        // Random presses over both banks
        for (int i = 0; i < 30; i++) begin
            kind = $urandom % 3;
            press_buttons(kind != 1 ? NF'(1) << ($urandom % NF) : '0,
                          kind != 0 ? NF'(1) << ($urandom % NF) : '0);
            repeat (1 + $urandom % 6) next_drive_slot();
        end
        wait_until_served();

        // Presses of the current floor and of a lit button
        press_buttons(NF'(1) << current_floor, NF'(1) << current_floor);
        wait_negedges(3);
        assert (car_lamps == '0) else show_mismatch("car_lamps", 32'(car_lamps), 32'h0);
        assert (hall_lamps == '0) else show_mismatch("hall_lamps", 32'(hall_lamps), 32'h0);
        hold_moving = 1;
        press_buttons(NF'(1) << ((current_floor + 2) % NF), '0);
        wait_negedges(3);
        lamp_snap = car_lamps;
        press_buttons(lamp_snap, '0);
        wait_negedges(3);
        assert (car_lamps == lamp_snap)
            else show_mismatch("car_lamps", 32'(car_lamps), 32'(lamp_snap));
        // A duplicate entry would put a second stop ahead of this floor
        press_buttons(NF'(1) << ((current_floor + 4) % NF), '0);
        wait_negedges(3);
        hold_moving = 0;
        wait_until_served();

        // Power off, then emergency
        check_blocked(1'b0);
        check_blocked(1'b1);

        // Door permissions when stopped, then while moving
        next_drive_slot();
        door_open_button = 1;
        @(negedge clock);
        assert (!door_open_allowed) else show_mismatch("door_open_allowed", 32'h1, 32'h0);
        @(negedge clock);
        assert (door_open_allowed) else show_mismatch("door_open_allowed", 32'h0, 32'h1);
        next_drive_slot();
        door_open_button = 0;
        hold_moving = 1;
        door_close_button = 1;
        wait_negedges(3);
        assert (!door_close_allowed) else show_mismatch("door_close_allowed", 32'h1, 32'h0);
        next_drive_slot();
        door_close_button = 0;
        hold_moving = 0;
        wait_until_served();

        // Full queue with the car held moving
        hold_moving = 1;
        for (int f = 0; f < NF; f++) begin
            press_buttons(NF'(1) << f, '0);
            press_buttons('0, NF'(1) << f);
        end
        wait_negedges(3);
        assert ($countones(car_lamps) + $countones(hall_lamps) == QD)
            else show_mismatch("lit lamps", 32'($countones(car_lamps) + $countones(hall_lamps)),
                               32'(QD));
        next_drive_slot();
        hold_moving = 0;
        wait_until_served();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- request_arbiter.sv
//////////////////////////////
// Combinational; hall calls win a tie and nothing is granted while full
//////////////////////////////
`timescale 1ns/1ps

module request_arbiter (
    input  elevator_pkg::floor_request_t car_request,
    input  elevator_pkg::floor_request_t hall_request,
    input  logic                         full,
    output logic                         car_grant,
    output logic                         hall_grant,
    output elevator_pkg::floor_request_t queue_write
);

    // Hall bank has fixed priority
    assign hall_grant = hall_request.valid && !full;
    assign car_grant  = car_request.valid && !hall_request.valid && !full;

    // Single write port of the shared queue
    always_comb begin
        queue_write = '0;
        if (hall_grant) begin
            queue_write = hall_request;
        end else if (car_grant) begin
            queue_write = car_request;
        end
    end

endmodule

//--- request_queue.sv
//////////////////////////////
// QUEUE_DEPTH must be a power of two; writes when full are dropped
//////////////////////////////
`timescale 1ns/1ps

module request_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  elevator_pkg::floor_request_t write,
    input  logic                         pop,
    output elevator_pkg::floor_t         head,
    output logic                         full,
    output logic                         empty
);
    import elevator_pkg::*;

    localparam int ADDR_W = $clog2(QUEUE_DEPTH);

    floor_t            mem [QUEUE_DEPTH];
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W:0]   count;
    logic              do_write;
    logic              do_pop;

    assign full     = count == (ADDR_W + 1)'(QUEUE_DEPTH);
    assign empty    = count == '0;
    assign do_write = write.valid && !full;
    assign do_pop   = pop && !empty;
    assign head     = mem[rd_ptr];

    // Storage
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= write.floor;
        end
    end

    // Pointers wrap on their own width
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- tb_clock_gen.sv
//////////////////////////////
// Reset releases 1 ns after the last reset edge
//////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 reset_n = 1'b1;
    end

endmodule
